// File: mips_params.svh
// ========================================
// MIPS core constants
// opcode, funct, ALU and memory encodings
// ========================================
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// primary opcodes
`define OP_RTYPE 6'b000000
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100
`define OP_J     6'b000010
`define OP_JAL   6'b000011

// R-type funct field
`define FN_ADD   6'b100000
`define FN_SUB   6'b100010
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_SLT   6'b101010
`define FN_SLL   6'b000000
`define FN_SRL   6'b000010
`define FN_JR    6'b001000

// ALU operation codes
`define ALU_AND  4'b0000
`define ALU_OR   4'b0001
`define ALU_ADD  4'b0010
`define ALU_SUB  4'b0110
`define ALU_SLT  4'b0111
`define ALU_SLL  4'b1000
`define ALU_SRL  4'b1001

// ALU-op classes from the main decoder
`define ALUOP_MEM   2'b00
`define ALUOP_BEQ   2'b01
`define ALUOP_RTYPE 2'b10

// data memory word address width
`define DMEM_AW  7
// jal link register
`define LINK_REG 5'd31

`endif

// File: mips_pkg.sv
// ========================================
// MIPS core shared types
// ========================================
package mips_pkg;

  // data or address word
  typedef logic [31:0] word_t;

  // register file index
  typedef logic [4:0] regAddr_t;

  // primary opcode, also funct
  typedef logic [5:0] opcode_t;

  // ALU operation code
  typedef logic [3:0] aluCtrl_t;

  // ALU-op class
  // memory add, branch subtract, R-type
  typedef logic [1:0] aluOpClass_t;

endpackage

// File: pcUnit.sv
// ========================================
// program counter
// holds PC and picks the next fetch address
// ========================================
`timescale 1ns/1ps

module pcUnit import mips_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [25:0] target,
  input  word_t       branchOffset,
  input  word_t       rsData,
  input  logic        branch,
  input  logic        aluZero,
  input  logic        jump,
  input  logic        jumpReg,
  output word_t       instrAddr,
  output word_t       linkAddr
);

  word_t pc;
  word_t pcPlus4;
  word_t branchAddr;
  word_t jumpAddr;
  word_t nextPc;
  logic  branchTaken;

  // sequential and link addresses
  assign pcPlus4 = pc + 32'd4;
  // jal writes PC+8
  assign linkAddr = pc + 32'd8;

  // beq taken when operands compare equal
  assign branchTaken = branch & aluZero;
  // word offset from the delay-free PC+4
  assign branchAddr = pcPlus4 + {branchOffset[29:0], 2'b00};
  // region-relative jump target
  assign jumpAddr = {pcPlus4[31:28], target, 2'b00};

  // next PC, highest priority first
  always_comb begin
    if (jumpReg) begin
      nextPc = rsData;
    end else if (jump) begin
      nextPc = jumpAddr;
    end else if (branchTaken) begin
      nextPc = branchAddr;
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

  assign instrAddr = pc;

endmodule

// File: controlUnit.sv
// ========================================
// main decoder
// opcode and funct to datapath controls
// ========================================
`timescale 1ns/1ps
`include "mips_params.svh"

module controlUnit import mips_pkg::*; (
  input  opcode_t     opcode,
  input  opcode_t     funct,
  output logic        regDst,
  output logic        link,
  output logic        aluSrc,
  output logic        memToReg,
  output logic        regWrite,
  output logic        memWrite,
  output logic        branch,
  output logic        jump,
  output logic        jumpReg,
  output aluOpClass_t aluOpClass
);

  always_comb begin
    // safe defaults, no state change
    regDst     = 1'b0;
    link       = 1'b0;
    aluSrc     = 1'b0;
    memToReg   = 1'b0;
    regWrite   = 1'b0;
    memWrite   = 1'b0;
    branch     = 1'b0;
    jump       = 1'b0;
    jumpReg    = 1'b0;
    aluOpClass = `ALUOP_MEM;
    case (opcode)
      `OP_RTYPE: begin
        regDst     = 1'b1;
        aluOpClass = `ALUOP_RTYPE;
        // jr only redirects the PC
        jumpReg    = (funct == `FN_JR);
        regWrite   = (funct != `FN_JR);
      end
      `OP_LW: begin
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      `OP_SW: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      `OP_BEQ: begin
        // subtract, zero flag decides
        branch     = 1'b1;
        aluOpClass = `ALUOP_BEQ;
      end
      `OP_J: begin
        jump = 1'b1;
      end
      `OP_JAL: begin
        // link address into r31
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: begin
        // unknown opcode behaves as a no-op
        regWrite = 1'b0;
        memWrite = 1'b0;
      end
    endcase
  end

endmodule

// File: aluControl.sv
// ========================================
// ALU control
// ALU-op class and funct to ALU code
// ========================================
`timescale 1ns/1ps
`include "mips_params.svh"

module aluControl import mips_pkg::*; (
  input  aluOpClass_t aluOpClass,
  input  opcode_t     funct,
  output aluCtrl_t    aluCtrl,
  output logic        isShift
);

  always_comb begin
    aluCtrl = `ALU_ADD;
    isShift = 1'b0;
    case (aluOpClass)
      // lw and sw address calculation
      `ALUOP_MEM: aluCtrl = `ALU_ADD;
      // beq compare
      `ALUOP_BEQ: aluCtrl = `ALU_SUB;
      `ALUOP_RTYPE: begin
        case (funct)
          `FN_ADD: aluCtrl = `ALU_ADD;
          `FN_SUB: aluCtrl = `ALU_SUB;
          `FN_AND: aluCtrl = `ALU_AND;
          `FN_OR:  aluCtrl = `ALU_OR;
          `FN_SLT: aluCtrl = `ALU_SLT;
          `FN_SLL: begin
            aluCtrl = `ALU_SLL;
            isShift = 1'b1;
          end
          `FN_SRL: begin
            aluCtrl = `ALU_SRL;
            isShift = 1'b1;
          end
          // jr and unknown funct, result unused
          default: aluCtrl = `ALU_ADD;
        endcase
      end
      default: aluCtrl = `ALU_ADD;
    endcase
  end

endmodule

// File: executeUnit.sv
// ========================================
// execute stage
// operand muxing, sign extension and ALU
// ========================================
`timescale 1ns/1ps
`include "mips_params.svh"

module executeUnit import mips_pkg::*; (
  input  word_t       rsData,
  input  word_t       rtData,
  input  logic [15:0] imm,
  input  logic [4:0]  shamt,
  input  logic        aluSrc,
  input  logic        isShift,
  input  aluCtrl_t    aluCtrl,
  output word_t       aluResult,
  output logic        aluZero
);

  word_t immExt;
  word_t opA;
  word_t opB;

  // sign-extended immediate
  assign immExt = {{16{imm[15]}}, imm};

  // shifts take the amount from shamt
  assign opA = isShift ? {27'd0, shamt} : rsData;
  // immediate for lw and sw
  assign opB = aluSrc ? immExt : rtData;

  // ========================================
  // ALU
  // ========================================
  always_comb begin
    case (aluCtrl)
      `ALU_ADD: aluResult = opA + opB;
      `ALU_SUB: aluResult = opA - opB;
      `ALU_AND: aluResult = opA & opB;
      `ALU_OR:  aluResult = opA | opB;
      // signed compare
      `ALU_SLT: aluResult = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
      // rt shifted by shamt
      `ALU_SLL: aluResult = opB << opA[4:0];
      `ALU_SRL: aluResult = opB >> opA[4:0];
      default:  aluResult = opA + opB;
    endcase
  end

  // equality flag for beq
  assign aluZero = (aluResult == '0);

endmodule

// File: registerWriteback.sv
// ========================================
// register file with writeback muxes
// 32 x 32, r0 hardwired to zero
// ========================================
`timescale 1ns/1ps
`include "mips_params.svh"

module registerWriteback import mips_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  regAddr_t rsAddr,
  input  regAddr_t rtAddr,
  input  regAddr_t rdAddr,
  input  logic     regDst,
  input  logic     link,
  input  logic     memToReg,
  input  logic     regWrite,
  input  word_t    aluResult,
  input  word_t    memRdata,
  input  word_t    linkAddr,
  output word_t    rsData,
  output word_t    rtData,
  output word_t    writeData
);

  word_t    regs [32];
  regAddr_t destAddr;

  // destination register
  // jal links into r31, R-type uses rd, lw uses rt
  always_comb begin
    if (link) begin
      destAddr = `LINK_REG;
    end else if (regDst) begin
      destAddr = rdAddr;
    end else begin
      destAddr = rtAddr;
    end
  end

  // write data select
  always_comb begin
    if (link) begin
      writeData = linkAddr;
    end else if (memToReg) begin
      writeData = memRdata;
    end else begin
      writeData = aluResult;
    end
  end

  // ========================================
  // register array
  // ========================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      regs <= '{default: '0};
    end else if (regWrite && (destAddr != '0)) begin
      regs[destAddr] <= writeData;
    end
  end

  // combinational reads, r0 forced to zero
  assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
  assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

// File: mipsCore.sv
// ========================================
// single-cycle MIPS core top level
// instruction port and data SRAM port
// ========================================
`timescale 1ns/1ps
`include "mips_params.svh"

module mipsCore import mips_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  output word_t               instrAddr,
  input  word_t               instr,
  output logic [`DMEM_AW-1:0] memAddr,
  output word_t               memWdata,
  output logic                memWen,
  input  word_t               memRdata,
  output word_t               resultData
);

  // instruction fields
  opcode_t     opcode;
  opcode_t     funct;
  regAddr_t    rsAddr;
  regAddr_t    rtAddr;
  regAddr_t    rdAddr;
  logic [4:0]  shamt;
  logic [15:0] imm;
  logic [25:0] target;
  word_t       branchOffset;

  // decoder outputs
  logic        regDst;
  logic        link;
  logic        aluSrc;
  logic        memToReg;
  logic        regWrite;
  logic        memWrite;
  logic        branch;
  logic        jump;
  logic        jumpReg;
  aluOpClass_t aluOpClass;

  // datapath
  aluCtrl_t    aluCtrl;
  logic        isShift;
  word_t       aluResult;
  logic        aluZero;
  word_t       rsData;
  word_t       rtData;
  word_t       linkAddr;

  assign opcode       = instr[31:26];
  assign rsAddr       = instr[25:21];
  assign rtAddr       = instr[20:16];
  assign rdAddr       = instr[15:11];
  assign shamt        = instr[10:6];
  assign funct        = instr[5:0];
  assign imm          = instr[15:0];
  assign target       = instr[25:0];
  // branch offset in words, sign-extended
  assign branchOffset = {{16{instr[15]}}, instr[15:0]};

  // ========================================
  // data memory port
  // ========================================
  // word address from the byte address
  assign memAddr  = aluResult[`DMEM_AW+1:2];
  assign memWdata = rtData;
  // active-low write strobe
  assign memWen   = ~memWrite;

  pcUnit uPcUnit (
    .clk(clk), .rst(rst), .target(target), .branchOffset(branchOffset),
    .rsData(rsData), .branch(branch), .aluZero(aluZero), .jump(jump),
    .jumpReg(jumpReg), .instrAddr(instrAddr), .linkAddr(linkAddr)
  );

  controlUnit uControlUnit (
    .opcode(opcode), .funct(funct), .regDst(regDst), .link(link),
    .aluSrc(aluSrc), .memToReg(memToReg), .regWrite(regWrite),
    .memWrite(memWrite), .branch(branch), .jump(jump), .jumpReg(jumpReg),
    .aluOpClass(aluOpClass)
  );

  aluControl uAluControl (
    .aluOpClass(aluOpClass), .funct(funct), .aluCtrl(aluCtrl), .isShift(isShift)
  );

  executeUnit uExecuteUnit (
    .rsData(rsData), .rtData(rtData), .imm(imm), .shamt(shamt),
    .aluSrc(aluSrc), .isShift(isShift), .aluCtrl(aluCtrl),
    .aluResult(aluResult), .aluZero(aluZero)
  );

  // writeback value also leaves the core for observation
  registerWriteback uRegisterWriteback (
    .clk(clk), .rst(rst), .rsAddr(rsAddr), .rtAddr(rtAddr), .rdAddr(rdAddr),
    .regDst(regDst), .link(link), .memToReg(memToReg), .regWrite(regWrite),
    .aluResult(aluResult), .memRdata(memRdata), .linkAddr(linkAddr),
    .rsData(rsData), .rtData(rtData), .writeData(resultData)
  );

endmodule

// File: mipsCore_chk.sv
// ========================================
// MIPS core checker
// assertions on fetch, memory strobe and r0
// ========================================
`timescale 1ns/1ps
`include "mips_params.svh"

module mipsCore_chk import mips_pkg::*; (
  input logic     clk,
  input logic     rst,
  input word_t    instrAddr,
  input word_t    instr,
  input logic     memWen,
  input regAddr_t rsAddr,
  input word_t    rsData,
  input regAddr_t rtAddr,
  input word_t    rtData
);

  opcode_t opcode;

  assign opcode = instr[31:26];

  // fetch address stays word aligned
  aAligned: assert property (@(posedge clk) disable iff (!rst)
    instrAddr[1:0] == 2'b00)
    else $error("instrAddr not word aligned");

  // write strobe only for sw
  aMemWen: assert property (@(posedge clk) disable iff (!rst)
    !memWen |-> (opcode == `OP_SW))
    else $error("memWen low for a non-store opcode");

  // r0 reads as zero on both ports
  aRegZero: assert property (@(posedge clk) disable iff (!rst)
    ((rsAddr != 5'd0) || (rsData == '0)) && ((rtAddr != 5'd0) || (rtData == '0)))
    else $error("register 0 read nonzero");

  // first cycle out of reset fetches address 0
  aResetPc: assert property (@(posedge clk) $rose(rst) |-> (instrAddr == '0))
    else $error("instrAddr not 0 after reset");

endmodule

bind mipsCore mipsCore_chk uCoreChk (
  .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr), .memWen(memWen),
  .rsAddr(rsAddr), .rsData(rsData), .rtAddr(rtAddr), .rtData(rtData)
);

// File: tb_mipsCore.sv
// ========================================
// testbench for the single-cycle MIPS core
// instruction table, data SRAM model, checks
// ========================================
`timescale 1ns/1ps
`include "mips_params.svh"

module tb_mipsCore import mips_pkg::*; ();

  localparam int CHK_NONE = 0;
  localparam int CHK_VALUE = 1;
  localparam int CHK_SHADOW = 2;
  localparam int START_TIMEOUT = 20;

  logic                clk;
  logic                rst;
  word_t               instrAddr;
  word_t               instr;
  logic [`DMEM_AW-1:0] memAddr;
  word_t               memWdata;
  logic                memWen;
  word_t               memRdata;
  word_t               resultData;

  // data SRAM and its untouched copy
  word_t dmem [128];
  word_t shadow [128];
  int    seed;

  // instruction table, one entry per presented instruction
  string stepName [$];
  word_t stepInstr [$];
  word_t stepAddr [$];
  word_t stepExpect [$];
  int    stepMode [$];

  mipsCore UUT (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
    .memAddr(memAddr), .memWdata(memWdata), .memWen(memWen),
    .memRdata(memRdata), .resultData(resultData)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // ========================================
  // data memory model
  // ========================================
  // combinational read, write on the rising edge
  assign memRdata = dmem[memAddr];

  always @(posedge clk) begin
    if (!memWen) begin
      dmem[memAddr] <= memWdata;
    end
  end

  // random contents, then known constants in words 0..3
  task automatic fillMemory();
    seed = 32'he5a5_7dcb;
    for (int i = 0; i < 128; i++) begin
      shadow[i[6:0]] = $random(seed);
    end
    shadow[0] = 32'h0000_0007;
    // -5
    shadow[1] = 32'hffff_fffb;
    shadow[2] = 32'h0f0f_00f0;
    shadow[3] = 32'h8000_0010;
    for (int i = 0; i < 128; i++) begin
      dmem[i[6:0]] <= shadow[i[6:0]];
    end
  endtask

  // instruction encoders, straight from the ISA field layout
  function automatic word_t rTypeWord(input regAddr_t rs, input regAddr_t rt,
                                      input regAddr_t rd, input logic [4:0] sh,
                                      input opcode_t fn);
    return {`OP_RTYPE, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t iTypeWord(input opcode_t op, input regAddr_t rs,
                                      input regAddr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jTypeWord(input opcode_t op, input word_t dest);
    return {op, dest[27:2]};
  endfunction

  task automatic addStep(input string name, input word_t iw, input word_t addr,
                         input word_t expVal, input int mode);
    stepName.push_back(name);
    stepInstr.push_back(iw);
    stepAddr.push_back(addr);
    stepExpect.push_back(expVal);
    stepMode.push_back(mode);
  endtask

  task automatic buildProgram();
    // constants from data memory
    addStep("lw r1", iTypeWord(`OP_LW, 5'd0, 5'd1, 16'd0), 32'h00, 32'h0000_0007, CHK_VALUE);
    addStep("lw r2", iTypeWord(`OP_LW, 5'd0, 5'd2, 16'd4), 32'h04, 32'hffff_fffb, CHK_VALUE);
    addStep("lw r3", iTypeWord(`OP_LW, 5'd0, 5'd3, 16'd8), 32'h08, 32'h0f0f_00f0, CHK_VALUE);
    addStep("lw r4", iTypeWord(`OP_LW, 5'd0, 5'd4, 16'd12), 32'h0c, 32'h8000_0010, CHK_VALUE);
    // arithmetic and logic
    addStep("add r5", rTypeWord(5'd1, 5'd2, 5'd5, 5'd0, `FN_ADD), 32'h10, 32'h2, CHK_VALUE);
    addStep("sub r6", rTypeWord(5'd1, 5'd2, 5'd6, 5'd0, `FN_SUB), 32'h14, 32'hc, CHK_VALUE);
    addStep("and r7", rTypeWord(5'd3, 5'd4, 5'd7, 5'd0, `FN_AND), 32'h18, 32'h10, CHK_VALUE);
    addStep("or r8", rTypeWord(5'd3, 5'd4, 5'd8, 5'd0, `FN_OR), 32'h1c, 32'h8f0f_00f0, CHK_VALUE);
    // -5 < 7, then 7 < -5
    addStep("slt r9", rTypeWord(5'd2, 5'd1, 5'd9, 5'd0, `FN_SLT), 32'h20, 32'h1, CHK_VALUE);
    addStep("slt r10", rTypeWord(5'd1, 5'd2, 5'd10, 5'd0, `FN_SLT), 32'h24, 32'h0, CHK_VALUE);
    // r0 write is dropped, readback must be zero
    addStep("add r0", rTypeWord(5'd1, 5'd1, 5'd0, 5'd0, `FN_ADD), 32'h28, 32'he, CHK_VALUE);
    addStep("or r11", rTypeWord(5'd0, 5'd0, 5'd11, 5'd0, `FN_OR), 32'h2c, 32'h0, CHK_VALUE);
    addStep("add r12", rTypeWord(5'd6, 5'd9, 5'd12, 5'd0, `FN_ADD), 32'h30, 32'hd, CHK_VALUE);
    // shifts
    addStep("sll r13", rTypeWord(5'd0, 5'd1, 5'd13, 5'd4, `FN_SLL), 32'h34, 32'h70, CHK_VALUE);
    addStep("srl r14", rTypeWord(5'd0, 5'd4, 5'd14, 5'd4, `FN_SRL), 32'h38, 32'h0800_0001,
            CHK_VALUE);
    // store then load back, then an untouched word
    addStep("sw r8", iTypeWord(`OP_SW, 5'd0, 5'd8, 16'd40), 32'h3c, 32'h0, CHK_NONE);
    addStep("lw r15", iTypeWord(`OP_LW, 5'd0, 5'd15, 16'd40), 32'h40, 32'h8f0f_00f0, CHK_VALUE);
    addStep("lw r16", iTypeWord(`OP_LW, 5'd0, 5'd16, 16'd100), 32'h44, 32'd25, CHK_SHADOW);
    // untaken, taken forward, taken backward
    addStep("beq untaken", iTypeWord(`OP_BEQ, 5'd1, 5'd2, 16'd5), 32'h48, 32'h0, CHK_NONE);
    addStep("beq fwd", iTypeWord(`OP_BEQ, 5'd15, 5'd8, 16'd3), 32'h4c, 32'h0, CHK_NONE);
    addStep("add r17", rTypeWord(5'd5, 5'd5, 5'd17, 5'd0, `FN_ADD), 32'h5c, 32'h4, CHK_VALUE);
    addStep("beq back", iTypeWord(`OP_BEQ, 5'd0, 5'd0, 16'hfffc), 32'h60, 32'h0, CHK_NONE);
    addStep("add r18", rTypeWord(5'd17, 5'd1, 5'd18, 5'd0, `FN_ADD), 32'h54, 32'hb, CHK_VALUE);
    // jumps, call and return
    addStep("j", jTypeWord(`OP_J, 32'h70), 32'h58, 32'h0, CHK_NONE);
    addStep("jal", jTypeWord(`OP_JAL, 32'h100), 32'h70, 32'h78, CHK_VALUE);
    addStep("add r19", rTypeWord(5'd31, 5'd0, 5'd19, 5'd0, `FN_ADD), 32'h100, 32'h78, CHK_VALUE);
    addStep("jr r31", rTypeWord(5'd31, 5'd0, 5'd0, 5'd0, `FN_JR), 32'h104, 32'h0, CHK_NONE);
    addStep("sub r20", rTypeWord(5'd12, 5'd1, 5'd20, 5'd0, `FN_SUB), 32'h78, 32'h6, CHK_VALUE);
    addStep("nop", rTypeWord(5'd0, 5'd0, 5'd0, 5'd0, `FN_SLL), 32'h7c, 32'h0, CHK_VALUE);
  endtask

  // ========================================
  // checks
  // ========================================
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "run aborted");
  endtask

  task automatic compareValue(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      abortRun("value check failed");
    end
  endtask

  // first fetch from address 0 once reset is released
  task automatic waitForStart();
    int cycles;
    cycles = 0;
    while (!(rst === 1'b1 && instrAddr === 32'd0)) begin
      if (cycles >= START_TIMEOUT) begin
        abortRun("core did not fetch from address 0 after reset release");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // one row per falling edge, result sampled after the decode settles
  task automatic runProgram();
    logic expWen;
    for (int i = 0; i < stepName.size(); i++) begin
      compareValue({stepName[i], " fetch"}, stepAddr[i], instrAddr);
      instr = stepInstr[i];
      #1;
      // write strobe low for stores only
      expWen = (stepInstr[i][31:26] == `OP_SW) ? 1'b0 : 1'b1;
      compareValue({stepName[i], " memWen"}, {31'd0, expWen}, {31'd0, memWen});
      if (stepMode[i] == CHK_VALUE) begin
        compareValue(stepName[i], stepExpect[i], resultData);
      end else if (stepMode[i] == CHK_SHADOW) begin
        compareValue(stepName[i], shadow[stepExpect[i][6:0]], resultData);
      end
      @(negedge clk);
    end
    // fall-through after the last nop
    compareValue("final fetch", 32'h80, instrAddr);
    instr = '0;
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b0;
    instr = '0;
    fillMemory();
    buildProgram();
    // reset for 16 cycles, released on a falling edge
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    waitForStart();
    runProgram();
    $display("all tests passed");
    $finish;
  end

endmodule

// File: tb.f
+incdir+.
mips_pkg.sv
pcUnit.sv
controlUnit.sv
aluControl.sv
executeUnit.sv
registerWriteback.sv
mipsCore.sv
mipsCore_chk.sv
tb_mipsCore.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing --assert
TOP       := tb_mipsCore
FILELIST  := tb.f
OBJDIR    := obj_dir
LOG       := sim.log
FAIL_MSG  := tests failed

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# verdict from the log, a crashed run counts as failure too
sim: $(OBJDIR)/V$(TOP)
	@./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
